// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

    // Data widths.
    typedef logic [31:0] word_t;   // One bus word.
    typedef logic [63:0] dword_t;  // Full ALU result, split into Z high and Z low.

    // Position of the operation field inside an instruction word.
    localparam int op_msb = 31;
    localparam int op_lsb = 27;

    // ALU operation codes as carried in instruction bits 31 to 27.
    typedef enum logic [4:0] {
        op_add = 5'd3,
        op_sub = 5'd4,
        op_and = 5'd5,
        op_or  = 5'd6,
        op_shr = 5'd7,
        op_shl = 5'd8,
        op_mul = 5'd15,
        op_neg = 5'd17,
        op_not = 5'd18,
        op_inc = 5'd31   // PC increment that only the control word ever sets.
    } opcode_t;

endpackage

// ==== rtl/ctrl_pkg.sv ====
package ctrl_pkg;

    // Index into the general register file.
    typedef logic [3:0] reg_idx_t;

    // Which block drives the shared bus in this microstep.
    typedef enum logic [2:0] {
        src_none  = 3'd0,   // Bus idles at zero.
        src_gpr   = 3'd1,
        src_pc    = 3'd2,
        src_mdr   = 3'd3,
        src_zhigh = 3'd4,
        src_zlow  = 3'd5,
        src_y     = 3'd6,
        src_ir    = 3'd7
    } bus_src_t;

    // One microstep of control, applied for a single clock cycle.
    typedef struct packed {
        bus_src_t         bus_src;  // Bus driver.
        reg_idx_t         gpr_out;  // Register read when bus_src is src_gpr.
        logic             gpr_in;   // Write the bus into a general register.
        reg_idx_t         gpr_sel;  // Register written when gpr_in is set.
        logic             pc_in;
        logic             ir_in;
        logic             mar_in;
        logic             mdr_in;
        logic             y_in;
        logic             z_in;     // Z takes the whole ALU result.
        logic             read;     // MDR loads from memory, not the bus.
        cpu_pkg::opcode_t alu_op;
    } ctrl_t;

endpackage

// ==== rtl/register_file.sv ====
`timescale 1ns/10ps

module register_file #(
    parameter int num_regs = 16
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              wr_en,
    input  ctrl_pkg::reg_idx_t wr_sel,
    input  ctrl_pkg::reg_idx_t rd_sel,
    input  cpu_pkg::word_t    data_in,
    output cpu_pkg::word_t    data_out
);

    cpu_pkg::word_t regs [num_regs];

    // Writes to an index past the last register are dropped.
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < num_regs; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en && (int'(wr_sel) < num_regs))
        begin
            regs[wr_sel] <= data_in;
        end
    end

    // Asynchronous read so the bus sees the register in the same cycle.
    always_comb
    begin
        if (int'(rd_sel) < num_regs)
        begin
            data_out = regs[rd_sel];
        end
        else
        begin
            data_out = '0;   // Unused index reads as zero.
        end
    end

endmodule

// ==== rtl/special_regs.sv ====
`timescale 1ns/10ps

module special_regs (
    input  logic            clk,
    input  logic            arst_n,
    input  ctrl_pkg::ctrl_t ctrl,
    input  cpu_pkg::word_t  bus,
    input  cpu_pkg::word_t  mem_data_in,
    input  cpu_pkg::dword_t alu_result,
    output cpu_pkg::word_t  pc,
    output cpu_pkg::word_t  ir,
    output cpu_pkg::word_t  mar,
    output cpu_pkg::word_t  mdr,
    output cpu_pkg::word_t  y,
    output cpu_pkg::word_t  z_high,
    output cpu_pkg::word_t  z_low
);

    cpu_pkg::word_t mdr_next;

    // Memory read takes priority over the bus as the MDR source.
    assign mdr_next = ctrl.read ? mem_data_in : bus;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc     <= '0;
            ir     <= '0;
            mar    <= '0;
            mdr    <= '0;
            y      <= '0;
            z_high <= '0;
            z_low  <= '0;
        end
        else
        begin
            if (ctrl.pc_in)
            begin
                pc <= bus;
            end
            if (ctrl.ir_in)
            begin
                ir <= bus;
            end
            if (ctrl.mar_in)
            begin
                mar <= bus;   // Address goes out to memory.
            end
            if (ctrl.mdr_in)
            begin
                mdr <= mdr_next;
            end
            if (ctrl.y_in)
            begin
                y <= bus;     // First ALU operand.
            end
            // Both halves load together from one result.
            if (ctrl.z_in)
            begin
                z_high <= alu_result[63:32];
                z_low  <= alu_result[31:0];
            end
        end
    end

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/10ps

module alu (
    input  cpu_pkg::opcode_t op,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    output cpu_pkg::dword_t  result
);

    logic signed [63:0] a_wide;
    logic signed [63:0] b_wide;
    logic signed [63:0] product;
    logic [4:0]         shamt;
    cpu_pkg::word_t     narrow;    // Result of the 32-bit operations.
    logic               use_wide;  // Take the full 64-bit product.

    // Signed operands so the upper half carries the sign of the product.
    assign a_wide  = {{32{a[31]}}, a};
    assign b_wide  = {{32{b[31]}}, b};
    assign product = a_wide * b_wide;

    assign shamt = b[4:0];   // Only five bits are meaningful for a 32-bit shift.

    always_comb
    begin
        narrow   = '0;
        use_wide = 1'b0;
        case (op)
            cpu_pkg::op_add:
            begin
                narrow = a + b;
            end
            cpu_pkg::op_sub:
            begin
                narrow = a - b;
            end
            cpu_pkg::op_and:
            begin
                narrow = a & b;
            end
            cpu_pkg::op_or:
            begin
                narrow = a | b;
            end
            cpu_pkg::op_shr:
            begin
                narrow = a >> shamt;   // Logical, zero fill.
            end
            cpu_pkg::op_shl:
            begin
                narrow = a << shamt;
            end
            cpu_pkg::op_mul:
            begin
                use_wide = 1'b1;
            end
            cpu_pkg::op_neg:
            begin
                narrow = ~b + 32'd1;
            end
            cpu_pkg::op_not:
            begin
                narrow = ~b;
            end
            // Program counter update. The bus carries the old PC.
            cpu_pkg::op_inc:
            begin
                narrow = b + 32'd1;
            end
            default:
            begin
                narrow = '0;
            end
        endcase
    end

    // Only mul fills the high word; everything else is zero-extended.
    always_comb
    begin
        if (use_wide)
        begin
            result = product;
        end
        else
        begin
            result = {32'd0, narrow};
        end
    end

endmodule

// ==== rtl/bus_mux.sv ====
`timescale 1ns/10ps

module bus_mux (
    input  ctrl_pkg::bus_src_t src,
    input  cpu_pkg::word_t     gpr,
    input  cpu_pkg::word_t     pc,
    input  cpu_pkg::word_t     ir,
    input  cpu_pkg::word_t     mdr,
    input  cpu_pkg::word_t     y,
    input  cpu_pkg::word_t     z_high,
    input  cpu_pkg::word_t     z_low,
    output cpu_pkg::word_t     bus
);

    // The encoded source names one driver, so there is nothing to arbitrate.
    always_comb
    begin
        case (src)
            ctrl_pkg::src_gpr:   bus = gpr;
            ctrl_pkg::src_pc:    bus = pc;
            ctrl_pkg::src_mdr:   bus = mdr;
            ctrl_pkg::src_zhigh: bus = z_high;
            ctrl_pkg::src_zlow:  bus = z_low;
            ctrl_pkg::src_y:     bus = y;
            ctrl_pkg::src_ir:    bus = ir;
            default:             bus = '0;   // src_none.
        endcase
    end

endmodule

// ==== rtl/datapath.sv ====
`timescale 1ns/10ps

module datapath #(
    parameter int num_regs = 16
) (
    input  logic            clk,
    input  logic            arst_n,
    input  ctrl_pkg::ctrl_t ctrl,
    input  cpu_pkg::word_t  mem_data_in,
    output cpu_pkg::word_t  bus_data,
    output cpu_pkg::word_t  pc,
    output cpu_pkg::word_t  ir,
    output cpu_pkg::word_t  mar,
    output cpu_pkg::word_t  mdr,
    output cpu_pkg::word_t  y,
    output cpu_pkg::word_t  z_high,
    output cpu_pkg::word_t  z_low
);

    cpu_pkg::word_t  gpr_data;     // Selected general register.
    cpu_pkg::dword_t alu_result;

    register_file #(
        .num_regs (num_regs)
    ) u_register_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_en    (ctrl.gpr_in),
        .wr_sel   (ctrl.gpr_sel),
        .rd_sel   (ctrl.gpr_out),
        .data_in  (bus_data),
        .data_out (gpr_data)
    );

    special_regs u_special_regs (
        .clk         (clk),
        .arst_n      (arst_n),
        .ctrl        (ctrl),
        .bus         (bus_data),
        .mem_data_in (mem_data_in),
        .alu_result  (alu_result),
        .pc          (pc),
        .ir          (ir),
        .mar         (mar),
        .mdr         (mdr),
        .y           (y),
        .z_high      (z_high),
        .z_low       (z_low)
    );

    // Y is always the first operand, the bus the second.
    alu u_alu (
        .op     (ctrl.alu_op),
        .a      (y),
        .b      (bus_data),
        .result (alu_result)
    );

    bus_mux u_bus_mux (
        .src    (ctrl.bus_src),
        .gpr    (gpr_data),
        .pc     (pc),
        .ir     (ir),
        .mdr    (mdr),
        .y      (y),
        .z_high (z_high),
        .z_low  (z_low),
        .bus    (bus_data)
    );

endmodule

// ==== test/datapath_tb.sv ====
`timescale 1ns/10ps

module datapath_tb;

    localparam int num_regs = 16;

    logic            clk;
    logic            arst_n;
    ctrl_pkg::ctrl_t ctrl;
    cpu_pkg::word_t  mem_data_in;
    cpu_pkg::word_t  bus_data;
    cpu_pkg::word_t  pc;
    cpu_pkg::word_t  ir;
    cpu_pkg::word_t  mar;
    cpu_pkg::word_t  mdr;
    cpu_pkg::word_t  y;
    cpu_pkg::word_t  z_high;
    cpu_pkg::word_t  z_low;

    int          errors    = 0;
    int          checks    = 0;
    logic [31:0] lcg_state = 32'd58961;

    datapath #(
        .num_regs (num_regs)
    ) UUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .ctrl        (ctrl),
        .mem_data_in (mem_data_in),
        .bus_data    (bus_data),
        .pc          (pc),
        .ir          (ir),
        .mar         (mar),
        .mdr         (mdr),
        .y           (y),
        .z_high      (z_high),
        .z_low       (z_low)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Watchdog for the whole run.
    initial
    begin
        #200000;
        $display("Simulation ran past its time limit and was stopped.");
        $display("TEST FAIL");
        $finish;
    end

    // With no driver selected the bus must idle at zero.
    bus_idle_check: assert property (@(posedge clk) disable iff (!arst_n)
        (ctrl.bus_src == ctrl_pkg::src_none) |-> (bus_data == '0))
    else
    begin
        errors++;
        $display("[FAIL] bus_idle expected 00000000 actual %h", $sampled(bus_data));
    end

    // Z holds its value on every edge without a z_in strobe.
    z_hold_check: assert property (@(posedge clk) disable iff (!arst_n)
        !$past(ctrl.z_in) |-> (z_low == $past(z_low) && z_high == $past(z_high)))
    else
    begin
        errors++;
        $display("Z changed on a clock edge without a z_in strobe.");
    end

    function automatic cpu_pkg::word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic ctrl_pkg::ctrl_t idle_ctrl();
        ctrl_pkg::ctrl_t c;
        c = '0;
        return c;
    endfunction

    // Reference ALU behavior with Y as a and the bus as b.
    function automatic cpu_pkg::dword_t expected_alu(input cpu_pkg::opcode_t op,
                                                     input cpu_pkg::word_t a,
                                                     input cpu_pkg::word_t b);
        cpu_pkg::word_t  abs_a;
        cpu_pkg::word_t  abs_b;
        cpu_pkg::dword_t mag;
        // Product of the magnitudes, negated when the signs differ.
        abs_a = a[31] ? 32'd0 - a : a;
        abs_b = b[31] ? 32'd0 - b : b;
        mag   = {32'd0, abs_a} * {32'd0, abs_b};
        case (op)
            cpu_pkg::op_add: return {32'd0, a + b};
            cpu_pkg::op_sub: return {32'd0, a - b};
            cpu_pkg::op_and: return {32'd0, a & b};
            cpu_pkg::op_or:  return {32'd0, a | b};
            cpu_pkg::op_shr: return {32'd0, a >> b[4:0]};
            cpu_pkg::op_shl: return {32'd0, a << b[4:0]};
            cpu_pkg::op_mul: return (a[31] ^ b[31]) ? 64'd0 - mag : mag;
            cpu_pkg::op_neg: return {32'd0, 32'd0 - b};
            cpu_pkg::op_not: return {32'd0, ~b};
            cpu_pkg::op_inc: return {32'd0, b + 32'd1};
            default:         return '0;
        endcase
    endfunction

    task automatic check_word(input string name, input cpu_pkg::word_t expected,
                              input cpu_pkg::word_t actual);
        checks++;
        assert (actual === expected)
        else
        begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // One microstep is active from this edge to the next.
    task automatic issue(input ctrl_pkg::ctrl_t c, input cpu_pkg::word_t data);
        @(posedge clk);
        ctrl        <= c;
        mem_data_in <= data;
    endtask

    // Lets the last strobe land, then samples mid-cycle.
    task automatic settle();
        issue(idle_ctrl(), '0);
        @(negedge clk);
    endtask

    task automatic mem_to_mdr(input cpu_pkg::word_t value);
        ctrl_pkg::ctrl_t c;
        c        = idle_ctrl();
        c.read   = 1'b1;
        c.mdr_in = 1'b1;
        issue(c, value);
    endtask

    task automatic load_gpr(input ctrl_pkg::reg_idx_t idx, input cpu_pkg::word_t value);
        ctrl_pkg::ctrl_t c;
        mem_to_mdr(value);
        c         = idle_ctrl();
        c.bus_src = ctrl_pkg::src_mdr;
        c.gpr_in  = 1'b1;
        c.gpr_sel = idx;
        issue(c, '0);
    endtask

    task automatic read_gpr(input ctrl_pkg::reg_idx_t idx, output cpu_pkg::word_t value);
        ctrl_pkg::ctrl_t c;
        c         = idle_ctrl();
        c.bus_src = ctrl_pkg::src_gpr;
        c.gpr_out = idx;
        issue(c, '0);
        @(negedge clk);
        value = bus_data;   // Combinational path is stable by now.
    endtask

    task automatic test_reset();
        cpu_pkg::word_t value;
        settle();
        check_word("reset pc", '0, pc);
        check_word("reset ir", '0, ir);
        check_word("reset mar", '0, mar);
        check_word("reset mdr", '0, mdr);
        check_word("reset y", '0, y);
        check_word("reset z_high", '0, z_high);
        check_word("reset z_low", '0, z_low);
        check_word("reset bus", '0, bus_data);
        for (int i = 0; i < num_regs; i++)
        begin
            read_gpr(ctrl_pkg::reg_idx_t'(i), value);
            check_word($sformatf("reset r%0d", i), '0, value);
        end
    endtask

    task automatic test_mdr_load();
        cpu_pkg::word_t value;
        cpu_pkg::word_t got;
        value = lcg_next();
        mem_to_mdr(value);
        settle();
        check_word("mdr load", value, mdr);   // One cycle after the read step.
        load_gpr(4'd5, value);
        read_gpr(4'd5, got);
        check_word("mdr to r5", value, got);
    endtask

    task automatic test_or_program();
        ctrl_pkg::ctrl_t c;
        cpu_pkg::word_t  got;
        load_gpr(4'd2, 32'h12);
        load_gpr(4'd3, 32'h14);
        load_gpr(4'd1, 32'h18);
        mem_to_mdr(32'h3091_8000);
        c         = idle_ctrl();
        c.bus_src = ctrl_pkg::src_mdr;
        c.ir_in   = 1'b1;
        issue(c, '0);
        settle();
        check_word("or program ir", 32'h3091_8000, ir);
        c         = idle_ctrl();
        c.bus_src = ctrl_pkg::src_gpr;
        c.gpr_out = 4'd2;
        c.y_in    = 1'b1;
        issue(c, '0);
        // Opcode decoded from the fetched instruction.
        c         = idle_ctrl();
        c.bus_src = ctrl_pkg::src_gpr;
        c.gpr_out = 4'd3;
        c.alu_op  = cpu_pkg::opcode_t'(ir[cpu_pkg::op_msb:cpu_pkg::op_lsb]);
        c.z_in    = 1'b1;
        issue(c, '0);
        c         = idle_ctrl();
        c.bus_src = ctrl_pkg::src_zlow;
        c.gpr_in  = 1'b1;
        c.gpr_sel = 4'd1;
        issue(c, '0);
        read_gpr(4'd1, got);
        check_word("or program r1", 32'h16, got);
        check_word("or program z_low", expected_alu(cpu_pkg::op_or, 32'h12, 32'h14), z_low);
    endtask

    task automatic test_fetch_increment();
        ctrl_pkg::ctrl_t c;
        cpu_pkg::word_t  old_pc;
        old_pc = lcg_next();
        mem_to_mdr(old_pc);
        c         = idle_ctrl();
        c.bus_src = ctrl_pkg::src_mdr;
        c.pc_in   = 1'b1;
        issue(c, '0);
        settle();
        check_word("fetch pc preset", old_pc, pc);
        c         = idle_ctrl();
        c.bus_src = ctrl_pkg::src_pc;
        c.mar_in  = 1'b1;
        c.alu_op  = cpu_pkg::op_inc;
        c.z_in    = 1'b1;
        issue(c, '0);
        c         = idle_ctrl();
        c.bus_src = ctrl_pkg::src_zlow;
        c.pc_in   = 1'b1;
        issue(c, '0);
        settle();
        check_word("fetch mar", old_pc, mar);
        check_word("fetch pc", old_pc + 32'd1, pc);
    endtask

    task automatic test_alu_ops();
        ctrl_pkg::ctrl_t  c;
        cpu_pkg::opcode_t op;
        cpu_pkg::word_t   a;
        cpu_pkg::word_t   b;
        cpu_pkg::dword_t  expected;
        op = op.first();
        repeat (op.num())
        begin
            a = lcg_next();
            b = lcg_next();
            mem_to_mdr(a);
            c         = idle_ctrl();
            c.bus_src = ctrl_pkg::src_mdr;
            c.y_in    = 1'b1;
            issue(c, '0);
            mem_to_mdr(b);
            c         = idle_ctrl();
            c.bus_src = ctrl_pkg::src_mdr;
            c.alu_op  = op;
            c.z_in    = 1'b1;
            issue(c, '0);
            settle();
            expected = expected_alu(op, a, b);
            check_word($sformatf("alu %s y", op.name()), a, y);
            check_word($sformatf("alu %s z_high", op.name()), expected[63:32], z_high);
            check_word($sformatf("alu %s z_low", op.name()), expected[31:0], z_low);
            op = op.next();
        end
    endtask

    // Consecutive LCG outputs never repeat, so all values are distinct.
    task automatic test_all_registers();
        cpu_pkg::word_t values [num_regs];
        cpu_pkg::word_t got;
        for (int i = 0; i < num_regs; i++)
        begin
            values[i] = lcg_next();
            load_gpr(ctrl_pkg::reg_idx_t'(i), values[i]);
        end
        for (int i = 0; i < num_regs; i++)
        begin
            read_gpr(ctrl_pkg::reg_idx_t'(i), got);
            check_word($sformatf("register r%0d", i), values[i], got);
        end
    endtask

    initial
    begin
        arst_n      <= 1'b0;
        ctrl        <= idle_ctrl();
        mem_data_in <= '0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        test_reset();
        test_mdr_load();
        test_or_program();
        test_fetch_increment();
        test_alu_ops();
        test_all_registers();
        settle();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
rtl/cpu_pkg.sv
rtl/ctrl_pkg.sv
rtl/register_file.sv
rtl/special_regs.sv
rtl/alu.sv
rtl/bus_mux.sv
rtl/datapath.sv
test/datapath_tb.sv

// ==== Makefile ====
# Verilator simulation of the single-bus datapath.

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module datapath_tb -f list.f -o sim_datapath
	./obj_dir/sim_datapath > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
